// ==== rtl/dcache_pkg.sv ====
package dcache_pkg;

	// default geometry, passed down from the top level
	parameter int DEF_SETS = 8;
	parameter int DEF_WORDS_PER_BLK = 2;

	localparam int DEF_IDX_W = $clog2(DEF_SETS);
	localparam int DEF_OFF_W = $clog2(DEF_WORDS_PER_BLK);
	localparam int DEF_TAG_W = 32 - DEF_IDX_W - DEF_OFF_W - 2;

	typedef logic [31:0] word_t;
	typedef logic [DEF_IDX_W-1:0] idx_t;
	typedef logic [DEF_OFF_W-1:0] off_t;
	typedef logic [DEF_TAG_W-1:0] tag_t;

	// datapath side
	typedef struct packed {
		logic ren;
		logic wen;
		logic atomic;
		logic halt;
		word_t addr;
		word_t store;
	} dp_req_t;

	typedef struct packed {
		logic hit;
		word_t load;
		logic flushed;
	} dp_rsp_t;

	// memory side, one word per transfer
	typedef struct packed {
		logic ren;
		logic wen;
		word_t addr;
		word_t store;
	} mem_req_t;

	typedef struct packed {
		logic busy;
		word_t load;
	} mem_rsp_t;

	// single array write, every field under its own enable
	typedef struct packed {
		idx_t set;
		logic way;
		off_t word;
		logic data_en;
		word_t data;
		logic tag_en;
		tag_t tag;
		logic valid_en;
		logic valid;
		logic dirty_en;
		logic dirty;
		logic lru_en;
		logic lru;
	} arr_wr_t;

	typedef enum logic [1:0] {
		IDLE,
		WRITEBACK,
		FILL,
		FLUSH
	} ctrl_state_t;

	typedef enum logic {
		WALK,
		DONE
	} flush_state_t;

endpackage

// ==== rtl/dcache_array.sv ====
`timescale 1ns/10ps

module dcache_array import dcache_pkg::*; #(
	parameter int SETS = DEF_SETS,
	parameter int WORDS_PER_BLK = DEF_WORDS_PER_BLK,
	localparam int IDX_W = $clog2(SETS),
	localparam int OFF_W = $clog2(WORDS_PER_BLK),
	localparam int TAG_W = 32 - IDX_W - OFF_W - 2
) (
	input logic CLK,
	input logic nRST,
	input word_t lookup_addr,
	input logic [IDX_W-1:0] rd_set,
	input logic rd_way,
	input logic [OFF_W-1:0] rd_word,
	input arr_wr_t wr,
	output logic hit,
	output logic hit_way,
	output word_t hit_data,
	output logic lru_way,
	output logic [TAG_W-1:0] victim_tag,
	output logic victim_dirty,
	output logic victim_valid,
	output word_t rd_data,
	output logic [TAG_W-1:0] rd_tag,
	output logic rd_dirty,
	output logic rd_valid
);

	// two ways per set
	word_t data_mem [SETS][2][WORDS_PER_BLK];
	logic [TAG_W-1:0] tag_mem [SETS][2];

	// line state, [set][way]
	logic [SETS-1:0][1:0] valid_q;
	logic [SETS-1:0][1:0] dirty_q;

	// lru bit names the way to replace next
	logic [SETS-1:0] lru_q;

	logic [TAG_W-1:0] l_tag;
	logic [IDX_W-1:0] l_idx;
	logic [OFF_W-1:0] l_off;
	logic [1:0] way_hit;

	// address split: tag | index | word | byte
	assign l_tag = lookup_addr[31 -: TAG_W];
	assign l_idx = lookup_addr[OFF_W+2 +: IDX_W];
	assign l_off = lookup_addr[2 +: OFF_W];

	assign way_hit[0] = valid_q[l_idx][0] && (tag_mem[l_idx][0] == l_tag);
	assign way_hit[1] = valid_q[l_idx][1] && (tag_mem[l_idx][1] == l_tag);

	assign hit = |way_hit;
	assign hit_way = way_hit[1];
	assign hit_data = data_mem[l_idx][hit_way][l_off];

	// victim is whatever the lru bit points at
	assign lru_way = lru_q[l_idx];
	assign victim_tag = tag_mem[l_idx][lru_way];
	assign victim_dirty = dirty_q[l_idx][lru_way];
	assign victim_valid = valid_q[l_idx][lru_way];

	// second read port for fill, write-back and flush
	assign rd_data = data_mem[rd_set][rd_way][rd_word];
	assign rd_tag = tag_mem[rd_set][rd_way];
	assign rd_dirty = dirty_q[rd_set][rd_way];
	assign rd_valid = valid_q[rd_set][rd_way];

	always_ff @(posedge CLK) begin
		if (wr.data_en) begin
			data_mem[wr.set][wr.way][wr.word] <= wr.data;
		end
		if (wr.tag_en) begin
			tag_mem[wr.set][wr.way] <= wr.tag;
		end
	end

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			valid_q <= '0;
			dirty_q <= '0;
			lru_q <= '0;
		end else begin
			if (wr.valid_en) begin
				valid_q[wr.set][wr.way] <= wr.valid;
			end
			if (wr.dirty_en) begin
				dirty_q[wr.set][wr.way] <= wr.dirty;
			end
			// lru is per set, way field is ignored here
			if (wr.lru_en) begin
				lru_q[wr.set] <= wr.lru;
			end
		end
	end

endmodule

// ==== rtl/dcache_ctrl.sv ====
`timescale 1ns/10ps

module dcache_ctrl import dcache_pkg::*; #(
	parameter int SETS = DEF_SETS,
	parameter int WORDS_PER_BLK = DEF_WORDS_PER_BLK,
	localparam int IDX_W = $clog2(SETS),
	localparam int OFF_W = $clog2(WORDS_PER_BLK),
	localparam int TAG_W = 32 - IDX_W - OFF_W - 2
) (
	input logic CLK,
	input logic nRST,
	input dp_req_t dp_req,
	output dp_rsp_t dp_rsp,
	output mem_req_t mem_req,
	input mem_rsp_t mem_rsp,
	input logic hit,
	input logic hit_way,
	input word_t hit_data,
	input logic lru_way,
	input logic [TAG_W-1:0] victim_tag,
	input logic victim_dirty,
	input logic victim_valid,
	input word_t rd_data,
	output logic [IDX_W-1:0] rd_set,
	output logic rd_way,
	output logic [OFF_W-1:0] rd_word,
	output arr_wr_t wr,
	input mem_req_t flush_mem_req,
	input arr_wr_t flush_wr,
	input logic [IDX_W-1:0] flush_rd_set,
	input logic flush_rd_way,
	input logic [OFF_W-1:0] flush_rd_word,
	input logic flush_done,
	output logic flushing
);

	ctrl_state_t state_q, state_d;
	logic [OFF_W-1:0] cnt_q, cnt_d;

	// ll/sc reservation
	word_t res_addr_q;
	logic res_valid_q, res_valid_d;
	logic ll_set;
	logic res_match;

	logic [TAG_W-1:0] req_tag;
	logic [IDX_W-1:0] req_idx;
	logic [OFF_W-1:0] req_off;
	logic access;
	logic last_word;

	assign req_tag = dp_req.addr[31 -: TAG_W];
	assign req_idx = dp_req.addr[OFF_W+2 +: IDX_W];
	assign req_off = dp_req.addr[2 +: OFF_W];
	assign access = dp_req.ren | dp_req.wen;
	assign last_word = (cnt_q == OFF_W'(WORDS_PER_BLK - 1));
	assign res_match = res_valid_q && (res_addr_q == dp_req.addr);

	// walker runs as long as we sit in FLUSH
	assign flushing = (state_q == FLUSH);

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			state_q <= IDLE;
			cnt_q <= '0;
			res_valid_q <= 1'b0;
		end else begin
			state_q <= state_d;
			cnt_q <= cnt_d;
			res_valid_q <= res_valid_d;
		end
	end

	always_ff @(posedge CLK) begin
		if (ll_set) begin
			res_addr_q <= dp_req.addr;
		end
	end

	always_comb begin
		state_d = state_q;
		cnt_d = cnt_q;
		res_valid_d = res_valid_q;
		ll_set = 1'b0;

		dp_rsp = '0;
		dp_rsp.load = hit_data;
		dp_rsp.flushed = flush_done;
		mem_req = '0;
		wr = '0;

		// victim line of the held request
		rd_set = req_idx;
		rd_way = lru_way;
		rd_word = cnt_q;

		case (state_q)
			IDLE: begin
				if (dp_req.halt) begin
					state_d = FLUSH;
				end else if (access && hit) begin
					dp_rsp.hit = 1'b1;
					wr.set = req_idx;
					wr.way = hit_way;
					wr.word = req_off;
					// point lru at the other way
					wr.lru_en = 1'b1;
					wr.lru = ~hit_way;
					if (dp_req.wen) begin
						wr.data = dp_req.store;
						wr.dirty = 1'b1;
						if (dp_req.atomic) begin
							// sc stores only with a matching reservation
							wr.data_en = res_match;
							wr.dirty_en = res_match;
							dp_rsp.load = word_t'(res_match);
							res_valid_d = 1'b0;
						end else begin
							wr.data_en = 1'b1;
							wr.dirty_en = 1'b1;
							if (res_match) begin
								res_valid_d = 1'b0;
							end
						end
					end else if (dp_req.atomic) begin
						ll_set = 1'b1;
						res_valid_d = 1'b1;
					end
				end else if (access) begin
					cnt_d = '0;
					if (victim_valid && victim_dirty) begin
						state_d = WRITEBACK;
					end else begin
						state_d = FILL;
					end
				end
			end

			WRITEBACK: begin
				mem_req.wen = 1'b1;
				mem_req.addr = {victim_tag, req_idx, cnt_q, 2'b00};
				mem_req.store = rd_data;
				if (!mem_rsp.busy) begin
					cnt_d = cnt_q + 1'b1;
					if (last_word) begin
						cnt_d = '0;
						state_d = FILL;
					end
				end
			end

			FILL: begin
				mem_req.ren = 1'b1;
				mem_req.addr = {req_tag, req_idx, cnt_q, 2'b00};
				if (!mem_rsp.busy) begin
					wr.set = req_idx;
					wr.way = lru_way;
					wr.word = cnt_q;
					wr.data_en = 1'b1;
					wr.data = mem_rsp.load;
					cnt_d = cnt_q + 1'b1;
					// line becomes valid and clean with the new tag
					if (last_word) begin
						wr.tag_en = 1'b1;
						wr.tag = req_tag;
						wr.valid_en = 1'b1;
						wr.valid = 1'b1;
						wr.dirty_en = 1'b1;
						wr.dirty = 1'b0;
						cnt_d = '0;
						state_d = IDLE;
					end
				end
			end

			FLUSH: begin
				// walker owns memory and array until reset
				mem_req = flush_mem_req;
				wr = flush_wr;
				rd_set = flush_rd_set;
				rd_way = flush_rd_way;
				rd_word = flush_rd_word;
			end

			default: begin
				state_d = IDLE;
			end
		endcase
	end

endmodule

// ==== rtl/dcache_flush.sv ====
`timescale 1ns/10ps

module dcache_flush import dcache_pkg::*; #(
	parameter int SETS = DEF_SETS,
	parameter int WORDS_PER_BLK = DEF_WORDS_PER_BLK,
	localparam int IDX_W = $clog2(SETS),
	localparam int OFF_W = $clog2(WORDS_PER_BLK),
	localparam int TAG_W = 32 - IDX_W - OFF_W - 2
) (
	input logic CLK,
	input logic nRST,
	input logic start,
	input mem_rsp_t mem_rsp,
	input logic [TAG_W-1:0] rd_tag,
	input word_t rd_data,
	input logic rd_dirty,
	input logic rd_valid,
	output mem_req_t mem_req,
	output arr_wr_t wr,
	output logic [IDX_W-1:0] rd_set,
	output logic rd_way,
	output logic [OFF_W-1:0] rd_word,
	output logic done
);

	flush_state_t state_q;
	logic [IDX_W-1:0] set_q;
	logic way_q;
	logic [OFF_W-1:0] word_q;

	logic walking;
	logic need_wb;
	logic advance;
	logic line_end;

	assign walking = start && (state_q == WALK);
	assign need_wb = rd_valid && rd_dirty;
	// clean or invalid entries pass in one cycle
	assign advance = walking && (!need_wb || !mem_rsp.busy);
	assign line_end = (word_q == OFF_W'(WORDS_PER_BLK - 1));

	assign rd_set = set_q;
	assign rd_way = way_q;
	assign rd_word = word_q;
	assign done = (state_q == DONE);

	always_comb begin
		mem_req = '0;
		if (walking && need_wb) begin
			mem_req.wen = 1'b1;
			mem_req.addr = {rd_tag, set_q, word_q, 2'b00};
			mem_req.store = rd_data;
		end

		// invalidate the line once its last word is out
		wr = '0;
		wr.set = set_q;
		wr.way = way_q;
		wr.word = word_q;
		wr.valid_en = advance && line_end;
		wr.dirty_en = advance && line_end;
	end

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			state_q <= WALK;
			set_q <= '0;
			way_q <= 1'b0;
			word_q <= '0;
		end else if (advance) begin
			if (line_end) begin
				word_q <= '0;
				way_q <= ~way_q;
				if (way_q) begin
					if (set_q == IDX_W'(SETS - 1)) begin
						state_q <= DONE;
					end else begin
						set_q <= set_q + 1'b1;
					end
				end
			end else begin
				word_q <= word_q + 1'b1;
			end
		end
	end

endmodule

// ==== rtl/dcache_top.sv ====
`timescale 1ns/10ps

module dcache_top import dcache_pkg::*; #(
	parameter int SETS = DEF_SETS,
	parameter int WORDS_PER_BLK = DEF_WORDS_PER_BLK,
	localparam int IDX_W = $clog2(SETS),
	localparam int OFF_W = $clog2(WORDS_PER_BLK),
	localparam int TAG_W = 32 - IDX_W - OFF_W - 2
) (
	input logic CLK,
	input logic nRST,
	input dp_req_t dp_req,
	output dp_rsp_t dp_rsp,
	output mem_req_t mem_req,
	input mem_rsp_t mem_rsp
);

	// lookup results
	logic arr_hit;
	logic arr_hit_way;
	word_t arr_hit_data;
	logic arr_lru_way;
	logic [TAG_W-1:0] victim_tag;
	logic victim_dirty;
	logic victim_valid;

	// shared read port
	logic [IDX_W-1:0] rd_set;
	logic rd_way;
	logic [OFF_W-1:0] rd_word;
	word_t rd_data;
	logic [TAG_W-1:0] rd_tag;
	logic rd_dirty;
	logic rd_valid;
	arr_wr_t arr_wr;

	// walker side
	logic flushing;
	logic flush_done;
	mem_req_t flush_mem_req;
	arr_wr_t flush_wr;
	logic [IDX_W-1:0] flush_rd_set;
	logic flush_rd_way;
	logic [OFF_W-1:0] flush_rd_word;

	dcache_array #(
		.SETS(SETS),
		.WORDS_PER_BLK(WORDS_PER_BLK)
	) u_array (
		.CLK(CLK),
		.nRST(nRST),
		.lookup_addr(dp_req.addr),
		.rd_set(rd_set),
		.rd_way(rd_way),
		.rd_word(rd_word),
		.wr(arr_wr),
		.hit(arr_hit),
		.hit_way(arr_hit_way),
		.hit_data(arr_hit_data),
		.lru_way(arr_lru_way),
		.victim_tag(victim_tag),
		.victim_dirty(victim_dirty),
		.victim_valid(victim_valid),
		.rd_data(rd_data),
		.rd_tag(rd_tag),
		.rd_dirty(rd_dirty),
		.rd_valid(rd_valid)
	);

	dcache_ctrl #(
		.SETS(SETS),
		.WORDS_PER_BLK(WORDS_PER_BLK)
	) u_ctrl (
		.CLK(CLK),
		.nRST(nRST),
		.dp_req(dp_req),
		.dp_rsp(dp_rsp),
		.mem_req(mem_req),
		.mem_rsp(mem_rsp),
		.hit(arr_hit),
		.hit_way(arr_hit_way),
		.hit_data(arr_hit_data),
		.lru_way(arr_lru_way),
		.victim_tag(victim_tag),
		.victim_dirty(victim_dirty),
		.victim_valid(victim_valid),
		.rd_data(rd_data),
		.rd_set(rd_set),
		.rd_way(rd_way),
		.rd_word(rd_word),
		.wr(arr_wr),
		.flush_mem_req(flush_mem_req),
		.flush_wr(flush_wr),
		.flush_rd_set(flush_rd_set),
		.flush_rd_way(flush_rd_way),
		.flush_rd_word(flush_rd_word),
		.flush_done(flush_done),
		.flushing(flushing)
	);

	dcache_flush #(
		.SETS(SETS),
		.WORDS_PER_BLK(WORDS_PER_BLK)
	) u_flush (
		.CLK(CLK),
		.nRST(nRST),
		.start(flushing),
		.mem_rsp(mem_rsp),
		.rd_tag(rd_tag),
		.rd_data(rd_data),
		.rd_dirty(rd_dirty),
		.rd_valid(rd_valid),
		.mem_req(flush_mem_req),
		.wr(flush_wr),
		.rd_set(flush_rd_set),
		.rd_way(flush_rd_way),
		.rd_word(flush_rd_word),
		.done(flush_done)
	);

endmodule

// ==== verif/dcache_mem.sv ====
`timescale 1ns/10ps

module dcache_mem import dcache_pkg::*; (
	input logic CLK,
	input logic nRST,
	input mem_req_t mem_req,
	output mem_rsp_t mem_rsp
);

	localparam logic [31:0] SEED = 32'd17208;

	// sparse word store, keyed by word address
	word_t mem [logic [29:0]];

	logic [31:0] rng_q;
	logic [31:0] rng_next;
	logic [1:0] wait_q;
	logic active;

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// unwritten words read back as their own byte address
	function automatic word_t read_word(input word_t addr);
		if (mem.exists(addr[31:2])) begin
			return mem[addr[31:2]];
		end
		return {addr[31:2], 2'b00};
	endfunction

	assign active = mem_req.ren || mem_req.wen;
	assign rng_next = xorshift32(rng_q);

	always_comb begin
		mem_rsp.busy = active && (wait_q != 2'd0);
		mem_rsp.load = read_word(mem_req.addr);
	end

	// 0 to 3 busy cycles per transfer
	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			rng_q <= SEED;
			wait_q <= SEED[1:0];
		end else if (active) begin
			if (wait_q != 2'd0) begin
				wait_q <= wait_q - 2'd1;
			end else begin
				rng_q <= rng_next;
				wait_q <= rng_next[1:0];
			end
		end
	end

	always @(posedge CLK) begin
		if (nRST && mem_req.wen && wait_q == 2'd0) begin
			mem[mem_req.addr[31:2]] = mem_req.store;
		end
	end

endmodule

// ==== verif/dcache_props.sv ====
`timescale 1ns/10ps

module dcache_props import dcache_pkg::*; (
	input logic CLK,
	input logic nRST,
	input dp_rsp_t dp_rsp,
	input mem_req_t mem_req,
	input mem_rsp_t mem_rsp
);

	int fail_cnt = 0;

	ren_wen_exclusive: assert property (
		@(posedge CLK) disable iff (!nRST) !(mem_req.ren && mem_req.wen)
	) else begin
		fail_cnt++;
		$error("memory ren and wen high together");
	end

	// held request while memory stalls
	req_stable_busy: assert property (
		@(posedge CLK) disable iff (!nRST)
		(mem_rsp.busy && (mem_req.ren || mem_req.wen)) |=> $stable(mem_req)
	) else begin
		fail_cnt++;
		$error("memory request changed while busy");
	end

	flushed_sticky: assert property (
		@(posedge CLK) disable iff (!nRST) dp_rsp.flushed |=> dp_rsp.flushed
	) else begin
		fail_cnt++;
		$error("flushed fell after rising");
	end

endmodule

bind dcache_top dcache_props u_props (
	.CLK(CLK),
	.nRST(nRST),
	.dp_rsp(dp_rsp),
	.mem_req(mem_req),
	.mem_rsp(mem_rsp)
);

// ==== verif/dcache_tb.sv ====
`timescale 1ns/10ps

module dcache_tb import dcache_pkg::*; ();

	localparam int TIMEOUT = 1000;
	localparam string TEST_FILE = "verif/dcache_tests.txt";

	logic CLK;
	logic nRST;
	dp_req_t dp_req;
	dp_rsp_t dp_rsp;
	mem_req_t mem_req;
	mem_rsp_t mem_rsp;

	int checks;
	int errors;
	int timeouts;

	dcache_top #(
		.SETS(DEF_SETS),
		.WORDS_PER_BLK(DEF_WORDS_PER_BLK)
	) dut (
		.CLK(CLK),
		.nRST(nRST),
		.dp_req(dp_req),
		.dp_rsp(dp_rsp),
		.mem_req(mem_req),
		.mem_rsp(mem_rsp)
	);

	dcache_mem u_mem (
		.CLK(CLK),
		.nRST(nRST),
		.mem_req(mem_req),
		.mem_rsp(mem_rsp)
	);

	// 8 ns period
	always begin
		#4 CLK = ~CLK;
	end

	task automatic check_word(input string op, input word_t addr, input word_t got,
		input word_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("[ERROR] %0t: %s at %h returned %h, expected %h",
				$time, op, addr, got, exp);
		end
	endtask

	// hold the request until hit is seen at a falling edge
	task automatic access_until_hit(input dp_req_t req, output logic ok, output word_t load);
		int cycles;
		cycles = 0;
		ok = 1'b0;
		load = '0;
		@(posedge CLK);
		dp_req <= req;
		while (!ok && cycles < TIMEOUT) begin
			@(negedge CLK);
			if (dp_rsp.hit) begin
				ok = 1'b1;
				load = dp_rsp.load;
			end
			cycles++;
		end
		// the access completes on this edge
		@(posedge CLK);
		dp_req <= '0;
	endtask

	task automatic halt_until_flushed(output logic ok);
		int cycles;
		dp_req_t req;
		cycles = 0;
		ok = 1'b0;
		req = '0;
		req.halt = 1'b1;
		@(posedge CLK);
		dp_req <= req;
		while (!ok && cycles < TIMEOUT) begin
			@(negedge CLK);
			ok = dp_rsp.flushed;
			cycles++;
		end
		@(posedge CLK);
		dp_req <= '0;
	endtask

	initial begin
		int fd;
		int n;
		string line;
		string op;
		word_t addr;
		word_t store;
		word_t exp;
		word_t got;
		logic ok;
		logic known;
		dp_req_t req;

		checks = 0;
		errors = 0;
		timeouts = 0;
		CLK = 1'b0;
		nRST = 1'b0;
		dp_req = '0;
		repeat (16) @(posedge CLK);
		nRST <= 1'b1;

		fd = $fopen(TEST_FILE, "r");
		if (fd == 0) begin
			$display("could not open the test file %s", TEST_FILE);
			errors++;
		end else begin
			while (timeouts == 0 && $fgets(line, fd) != 0) begin
				n = $sscanf(line, "%s %h %h %h", op, addr, store, exp);
				if (n < 4) begin
					continue;
				end
				req = '0;
				req.addr = addr;
				req.store = store;
				known = 1'b1;
				case (op)
					"R": req.ren = 1'b1;
					"W": req.wen = 1'b1;
					"LL": begin
						req.ren = 1'b1;
						req.atomic = 1'b1;
					end
					"SC": begin
						req.wen = 1'b1;
						req.atomic = 1'b1;
					end
					"H", "M": req = '0;
					default: known = 1'b0;
				endcase

				if (!known) begin
					$display("unknown operation %s in the test file", op);
					errors++;
				end else if (op == "M") begin
					got = u_mem.read_word(addr);
					check_word(op, addr, got, exp);
				end else if (op == "H") begin
					halt_until_flushed(ok);
					if (!ok) begin
						$display("flushed did not rise within %0d cycles after halt", TIMEOUT);
						timeouts++;
					end
				end else begin
					access_until_hit(req, ok, got);
					if (!ok) begin
						$display("%s at address %h got no hit within %0d cycles",
							op, addr, TIMEOUT);
						timeouts++;
					end else if (op != "W") begin
						check_word(op, addr, got, exp);
					end
				end
			end
			$fclose(fd);
		end

		if (checks == 0) begin
			$display("no checks were run");
			errors++;
		end

		$display("checks %0d, errors %0d, timeouts %0d, assertion failures %0d",
			checks, errors, timeouts, dut.u_props.fail_cnt);
		if (errors == 0 && timeouts == 0 && dut.u_props.fail_cnt == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

// ==== verilog.f ====
rtl/dcache_pkg.sv
rtl/dcache_array.sv
rtl/dcache_ctrl.sv
rtl/dcache_flush.sv
rtl/dcache_top.sv
verif/dcache_mem.sv
verif/dcache_props.sv
verif/dcache_tb.sv

// ==== verif/dcache_tests.txt ====
# op addr store expected, all hex
# ops: R W LL SC H M, expected unused for W and H
R 00000100 00000000 00000100
R 00000100 00000000 00000100
R 00000104 00000000 00000104
W 00000108 11111111 00000000
R 00000108 00000000 11111111
W 0000010C 22222222 00000000
R 0000010C 00000000 22222222
R 00000108 00000000 11111111
W 00000010 AAAA0001 00000000
W 00000050 BBBB0001 00000000
W 00000090 CCCC0001 00000000
R 00000010 00000000 AAAA0001
R 00000014 00000000 00000014
R 00000090 00000000 CCCC0001
R 00000050 00000000 BBBB0001
LL 00000018 00000000 00000018
SC 00000018 12345678 00000001
R 00000018 00000000 12345678
SC 00000018 55555555 00000000
R 00000018 00000000 12345678
LL 0000001C 00000000 0000001C
W 0000001C 66666666 00000000
SC 0000001C 77777777 00000000
R 0000001C 00000000 66666666
H 00000000 00000000 00000000
M 00000108 00000000 11111111
M 0000010C 00000000 22222222
M 00000090 00000000 CCCC0001
M 00000010 00000000 AAAA0001
M 00000050 00000000 BBBB0001
M 00000018 00000000 12345678
M 0000001C 00000000 66666666
M 00000100 00000000 00000100
